// File: compile.f
+incdir+dv
common/cnn_cfg_pkg.sv
common/cnn_inst_pkg.sv
logic/inst_decoder.sv
logic/mem_port_mux.sv
logic/coef_loader.sv
pe/feature_fetch.sv
pe/pe_array.sv
logic/cnn_top.sv
dv/cnn_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = cnn_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/cnn_tb_tasks.svh
`ifndef CNN_TB_TASKS_SVH
`define CNN_TB_TASKS_SVH

////////////////////
// Compare tasks

task automatic check_result(result_row_t exp, result_row_t got);
	if (got !== exp) begin
		$display("ERR res_data exp=%h got=%h", exp, got);
		err_val++;
	end
endtask

task automatic check_mem_cmd(logic [MEM_ADDR_W-1:0] exp_addr, logic [LEN_W-1:0] exp_len,
		logic [MEM_ADDR_W-1:0] got_addr, logic [LEN_W-1:0] got_len);
	if (got_addr !== exp_addr) begin
		$display("ERR mem_addr exp=%h got=%h", exp_addr, got_addr);
		err_val++;
	end
	if (got_len !== exp_len) begin
		$display("ERR mem_len exp=%h got=%h", exp_len, got_len);
		err_val++;
	end
endtask

////////////////////
// Reference model

// Dot product, bias, shift, ReLU, then clamp
function automatic result_row_t expect_row(window_t feat, weight_row_t w, bias_row_t b,
		logic use_bias, int shift, logic relu);
	result_row_t r;
	int acc;
	for (int l = 0; l < N_LANES; l++) begin
		acc = 0;
		for (int k = 0; k < N_TAPS; k++)
			acc += int'(pixel_t'(feat[8*k +: 8])) * int'(pixel_t'(w[WIN_W*l + 8*k +: 8]));
		if (use_bias)
			acc += int'(bias_t'(b[16*l +: 16]));
		acc = acc >>> shift;
		if (relu && acc < 0)
			acc = 0;
		if (acc > 32767)
			acc = 32767;
		else if (acc < -32768)
			acc = -32768;
		r[16*l +: 16] = 16'(acc);
	end
	return r;
endfunction

// Results still owed by instructions not yet fetched
function automatic int pending_results();
	int n;
	n = 0;
	foreach (inst_q[i])
		if (inst_q[i].opcode == COMPUTE)
			n += int'(inst_q[i].count);
	return n;
endfunction

////////////////////
// Drive tasks

task automatic push_inst(opcode_t op, int addr, int count, int row, int shift,
		logic relu, logic use_bias);
	inst_t i;
	i = '0;
	i.opcode = op;
	i.mem_addr = MEM_ADDR_W'(addr);
	i.count = LEN_W'(count);
	i.row = ROW_ADDR_W'(row);
	i.shift = 4'(shift);
	i.relu = relu;
	i.use_bias = use_bias;
	inst_q.push_back(i);
	if (op != NOP) begin
		cmd_addr_q.push_back(i.mem_addr);
		cmd_len_q.push_back(i.count);
	end
endtask

task automatic fill_random(int addr, int count);
	for (int n = 0; n < count; n++)
		mem[addr + n] = window_t'({$random(seed), $random(seed), $random(seed)});
endtask

task automatic fill_const(int addr, int count, pixel_t p);
	for (int n = 0; n < count; n++)
		mem[addr + n] = {N_TAPS{p}};
endtask

// Word n goes to lane n mod N_LANES of row + n / N_LANES
task automatic load_weights(int addr, int count, int row);
	for (int n = 0; n < count; n++)
		wmod[row + n / N_LANES][WIN_W*(n % N_LANES) +: WIN_W] = mem[addr + n];
	push_inst(LOAD_W, addr, count, row, 0, 1'b0, 1'b0);
endtask

task automatic load_biases(int addr, int count, int row);
	for (int n = 0; n < count; n++)
		bmod[row + n] = mem[addr + n][$bits(bias_row_t)-1:0];
	push_inst(LOAD_B, addr, count, row, 0, 1'b0, 1'b0);
endtask

task automatic compute_windows(int addr, int count, int row, logic use_bias, int shift,
		logic relu);
	for (int n = 0; n < count; n++)
		ref_q.push_back(expect_row(mem[addr + n], wmod[row], bmod[row], use_bias, shift, relu));
	push_inst(COMPUTE, addr, count, row, shift, relu, use_bias);
endtask

task automatic insert_nop();
	push_inst(NOP, 0, 0, 0, 0, 1'b0, 1'b0);
endtask

////////////////////
// Wait tasks

task automatic wait_idle(int limit);
	int  cycles;
	logic done;
	cycles = 0;
	done = 1'b0;
	while (!done && cycles < limit) begin
		@(negedge clk);
		cycles++;
		done = (inst_q.size() == 0) && (idle === 1'b1) && (ref_q.size() == 0);
	end
	if (!done) begin
		$display("Timeout after %0d cycles waiting for the DUT to finish", limit);
		timeouts++;
	end
endtask

`endif

// File: dv/cnn_tb.sv
`timescale 1ns/1ps

module cnn_tb import cnn_cfg_pkg::*, cnn_inst_pkg::*; ();

	localparam int WIN_W = $bits(window_t);

	logic                  clk = 1'b0;
	logic                  reset;
	logic                  inst_req, inst_empty;
	inst_t                 instruct;
	logic [MEM_ADDR_W-1:0] mem_addr;
	logic [LEN_W-1:0]      mem_len;
	logic                  mem_conf, mem_req, mem_empty;
	window_t               mem_data;
	logic                  res_valid, idle;
	result_row_t           res_data;

	int                    seed = 74;
	int                    err_val = 0;
	int                    err_proto = 0;
	int                    timeouts = 0;
	logic                  stall_en = 1'b0; // Random mem_empty
	logic                  gap_en = 1'b0;   // Random inst_empty
	inst_t                 inst_q [$];      // Instruction FIFO contents
	result_row_t           ref_q [$];       // Expected results in order
	logic [MEM_ADDR_W-1:0] cmd_addr_q [$];
	logic [LEN_W-1:0]      cmd_len_q [$];
	window_t               mem [1024];
	weight_row_t           wmod [64];       // Model of the coefficient buffers
	bias_row_t             bmod [64];
	logic [MEM_ADDR_W-1:0] rd_ptr;
	logic [LEN_W-1:0]      rd_left;
	logic                  idle_q = 1'b1;
	logic                  pop_inst, fetch_word;

	always #2 clk = ~clk;

	cnn_top #(.ROWS(64)) u_cnn_top (
		.clk(clk), .reset(reset),
		.inst_req(inst_req), .inst_empty(inst_empty), .instruct(instruct),
		.mem_addr(mem_addr), .mem_len(mem_len), .mem_conf(mem_conf), .mem_req(mem_req),
		.mem_empty(mem_empty), .mem_data(mem_data),
		.res_valid(res_valid), .res_data(res_data), .idle(idle)
	);

	`include "cnn_tb_tasks.svh"

	////////////////////
	// Instruction FIFO, memory and result monitor

	always begin
		@(posedge clk);
		pop_inst = 1'b0;
		fetch_word = 1'b0;
		if (!reset) begin
			if (res_valid && ref_q.size() == 0) begin
				$display("res_valid seen with no result expected");
				err_proto++;
			end else if (res_valid) begin
				check_result(ref_q.pop_front(), res_data);
			end
			// A finished instruction has delivered all its results
			if (idle && !idle_q && ref_q.size() != pending_results()) begin
				$display("Instruction finished with %0d results missing",
					ref_q.size() - pending_results());
				err_proto++;
			end
			if (mem_conf && cmd_addr_q.size() == 0) begin
				$display("mem_conf pulsed with no memory command expected");
				err_proto++;
			end else if (mem_conf) begin
				check_mem_cmd(cmd_addr_q.pop_front(), cmd_len_q.pop_front(), mem_addr, mem_len);
			end
			if (mem_conf) begin
				rd_ptr = mem_addr;
				rd_left = mem_len;
			end
			if (mem_req && (mem_empty || rd_left == '0)) begin
				$display("mem_req issued while the memory was empty or the burst was done");
				err_proto++;
			end
			fetch_word = mem_req;
			if (inst_req && (inst_empty || inst_q.size() == 0)) begin
				$display("inst_req issued while the instruction FIFO was empty");
				err_proto++;
			end else begin
				pop_inst = inst_req;
			end
			idle_q = idle;
		end
		#1;
		if (fetch_word) begin
			mem_data = mem[rd_ptr[9:0]]; // Word answers last cycle's req
			rd_ptr++;
			rd_left--;
		end
		if (pop_inst)
			instruct = inst_q.pop_front();
		inst_empty = (inst_q.size() == 0) || (gap_en && ($random(seed) % 3 == 0));
		mem_empty = stall_en && ($random(seed) % 4 != 0);
	end

	////////////////////
	// Directed tests

	task automatic basic_dot_product();
		fill_random(0, 4);
		fill_random(16, 1);
		fill_random(32, 6);
		load_weights(0, 4, 0);
		load_biases(16, 1, 0);
		compute_windows(32, 6, 0, 1'b0, 0, 1'b0);
		wait_idle(500);
	endtask

	// Two weight rows, bias on, several shift amounts
	task automatic bias_and_shift();
		fill_random(64, 8);
		fill_random(80, 2);
		fill_random(96, 8);
		load_weights(64, 8, 4);
		load_biases(80, 2, 4);
		compute_windows(96, 8, 5, 1'b1, 3, 1'b0);
		compute_windows(96, 8, 4, 1'b1, 7, 1'b0);
		wait_idle(800);
	endtask

	// Lanes 0 and 1 hit both 16-bit limits
	task automatic relu_saturation();
		fill_const(128, 1, 8'sh7f);
		fill_const(129, 1, -8'sd128);
		fill_random(130, 2);
		fill_const(144, 2, 8'sh7f);
		fill_const(146, 2, -8'sd128);
		fill_random(148, 2);
		load_weights(128, 4, 8);
		compute_windows(144, 6, 8, 1'b0, 0, 1'b0);
		compute_windows(144, 6, 8, 1'b0, 0, 1'b1); // Same windows with ReLU
		wait_idle(800);
	endtask

	task automatic mem_backpressure();
		stall_en = 1'b1;
		fill_random(192, 4);
		fill_random(208, 1);
		fill_random(224, 12);
		load_weights(192, 4, 12);
		load_biases(208, 1, 12);
		compute_windows(224, 12, 12, 1'b1, 2, 1'b1);
		wait_idle(3000);
		stall_en = 1'b0;
	endtask

	task automatic inst_stream();
		gap_en = 1'b1;
		fill_random(256, 8);
		fill_random(272, 2);
		fill_random(288, 5);
		load_weights(256, 8, 20);
		load_biases(272, 2, 20);
		insert_nop();
		compute_windows(288, 5, 20, 1'b1, 1, 1'b0);
		compute_windows(288, 5, 21, 1'b0, 4, 1'b1);
		insert_nop();
		wait_idle(1500);
		gap_en = 1'b0;
	endtask

	initial begin
		reset = 1'b1;
		inst_empty = 1'b1;
		instruct = '0;
		mem_empty = 1'b0;
		mem_data = '0;
		rd_ptr = '0;
		rd_left = '0;
		repeat (3) @(posedge clk);
		#1;
		if (inst_req !== 1'b0 || mem_conf !== 1'b0 || mem_req !== 1'b0 ||
				res_valid !== 1'b0 || idle !== 1'b1) begin
			$display("Outputs are not at their reset values");
			err_proto++;
		end
		reset = 1'b0;
		for (int t = 0; t < 5 && timeouts == 0; t++) begin
			case (t)
				0: basic_dot_product();
				1: bias_and_shift();
				2: relu_saturation();
				3: mem_backpressure();
				default: inst_stream();
			endcase
		end
		$display("Errors: %0d value, %0d protocol, %0d timeout", err_val, err_proto, timeouts);
		if (err_val == 0 && err_proto == 0 && timeouts == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: logic/cnn_top.sv
`timescale 1ns/1ps

module cnn_top import cnn_cfg_pkg::*, cnn_inst_pkg::*; #(
	parameter int ROWS = 64
) (
	input  logic                  clk,
	input  logic                  reset,

	output logic                  inst_req,
	input  logic                  inst_empty,
	input  inst_t                 instruct,

	output logic [MEM_ADDR_W-1:0] mem_addr,
	output logic [LEN_W-1:0]      mem_len,
	output logic                  mem_conf,
	output logic                  mem_req,
	input  logic                  mem_empty,
	input  window_t               mem_data,

	output logic                  res_valid,
	output result_row_t           res_data,
	output logic                  idle
);

	inst_t    cur;
	mem_sel_t sel;
	logic     w_start, b_start, f_start;
	logic     w_busy, b_busy, f_busy;

	logic [MEM_ADDR_W-1:0] w_addr, b_addr, f_addr;
	logic [LEN_W-1:0]      w_len, b_len, f_len;
	logic                  w_conf, b_conf, f_conf;
	logic                  w_req, b_req, f_req;
	logic                  w_empty, b_empty, f_empty;

	logic [ROW_ADDR_W-1:0] w_row_addr, b_row_addr;
	weight_row_t           weights;
	bias_row_t             bias;
	window_t               win;
	logic                  win_valid, pipe_busy;
	logic                  cfg_use_bias, cfg_relu;
	logic [3:0]            cfg_shift;

	inst_decoder u_dec (
		.clk(clk), .reset(reset),
		.inst_empty(inst_empty), .instruct(instruct), .inst_req(inst_req),
		.w_busy(w_busy), .b_busy(b_busy), .f_busy(f_busy),
		.w_start(w_start), .b_start(b_start), .f_start(f_start),
		.cur(cur), .sel(sel), .idle(idle)
	);

	mem_port_mux u_mux (
		.sel(sel),
		.w_addr(w_addr), .w_len(w_len), .w_conf(w_conf), .w_req(w_req),
		.b_addr(b_addr), .b_len(b_len), .b_conf(b_conf), .b_req(b_req),
		.f_addr(f_addr), .f_len(f_len), .f_conf(f_conf), .f_req(f_req),
		.mem_empty(mem_empty),
		.mem_addr(mem_addr), .mem_len(mem_len), .mem_conf(mem_conf), .mem_req(mem_req),
		.w_empty(w_empty), .b_empty(b_empty), .f_empty(f_empty)
	);

	////////////////////
	// Coefficient buffers

	coef_loader #(.ROWS(ROWS), .LANES_PER_ROW(N_LANES), .row_t(weight_row_t)) u_wload (
		.clk(clk), .reset(reset),
		.start(w_start), .mem_addr_in(cur.mem_addr), .count(cur.count), .row(cur.row),
		.addr(w_addr), .len(w_len), .conf(w_conf), .empty(w_empty), .req(w_req),
		.mem_data(mem_data), .rd_row(w_row_addr), .rd_data(weights), .busy(w_busy)
	);

	coef_loader #(.ROWS(ROWS), .LANES_PER_ROW(1), .row_t(bias_row_t)) u_bload (
		.clk(clk), .reset(reset),
		.start(b_start), .mem_addr_in(cur.mem_addr), .count(cur.count), .row(cur.row),
		.addr(b_addr), .len(b_len), .conf(b_conf), .empty(b_empty), .req(b_req),
		.mem_data(mem_data), .rd_row(b_row_addr), .rd_data(bias), .busy(b_busy)
	);

	////////////////////
	// Feature path

	feature_fetch u_fetch (
		.clk(clk), .reset(reset),
		.start(f_start), .mem_addr_in(cur.mem_addr), .count(cur.count), .row(cur.row),
		.use_bias(cur.use_bias), .shift(cur.shift), .relu(cur.relu),
		.addr(f_addr), .len(f_len), .conf(f_conf), .empty(f_empty), .req(f_req),
		.mem_data(mem_data), .pipe_busy(pipe_busy),
		.w_row_addr(w_row_addr), .b_row_addr(b_row_addr),
		.win(win), .win_valid(win_valid),
		.cfg_use_bias(cfg_use_bias), .cfg_shift(cfg_shift), .cfg_relu(cfg_relu),
		.busy(f_busy)
	);

	pe_array u_pe (
		.clk(clk), .reset(reset),
		.win(win), .win_valid(win_valid), .weights(weights), .bias(bias),
		.use_bias(cfg_use_bias), .shift(cfg_shift), .relu(cfg_relu),
		.res_data(res_data), .res_valid(res_valid), .pipe_busy(pipe_busy)
	);

endmodule

// File: pe/pe_array.sv
`timescale 1ns/1ps

module pe_array import cnn_cfg_pkg::*; (
	input  logic        clk,
	input  logic        reset,

	input  window_t     win,
	input  logic        win_valid,
	input  weight_row_t weights,
	input  bias_row_t   bias,
	input  logic        use_bias,
	input  logic [3:0]  shift,
	input  logic        relu,

	output result_row_t res_data,
	output logic        res_valid,
	output logic        pipe_busy
);

	localparam int PIX_W = $bits(pixel_t);
	localparam int WIN_W = $bits(window_t);
	localparam int RES_W = $bits(result_t);
	localparam acc_t SAT_MAX = acc_t'(32767);
	localparam acc_t SAT_MIN = -acc_t'(32768);

	logic signed [2*PIX_W-1:0] prod_q [N_LANES][N_TAPS];
	acc_t        sum_c [N_LANES];
	acc_t        acc_q [N_LANES];
	result_row_t res_q;
	logic        v1, v2, v3;

	// ReLU first, then clamp into 16 bits
	function automatic result_t clamp(acc_t v, logic relu_en);
		acc_t r;
		r = (relu_en && v < 0) ? acc_t'(0) : v;
		if (r > SAT_MAX)
			r = SAT_MAX;
		else if (r < SAT_MIN)
			r = SAT_MIN;
		return result_t'(r);
	endfunction

	////////////////////
	// Stage 1, 36 products

	always_ff @(posedge clk) begin
		if (win_valid) begin
			for (int l = 0; l < N_LANES; l++) begin
				for (int k = 0; k < N_TAPS; k++) begin
					prod_q[l][k] <= pixel_t'(win[PIX_W*k +: PIX_W]) *
						pixel_t'(weights[WIN_W*l + PIX_W*k +: PIX_W]);
				end
			end
		end
	end

	////////////////////
	// Stage 2, lane sums and bias

	always_comb begin
		for (int l = 0; l < N_LANES; l++) begin
			sum_c[l] = use_bias ? acc_t'(bias_t'(bias[RES_W*l +: RES_W])) : acc_t'(0);
			for (int k = 0; k < N_TAPS; k++)
				sum_c[l] += acc_t'(prod_q[l][k]);
		end
	end

	always_ff @(posedge clk) begin
		if (v1)
			acc_q <= sum_c;
	end

	////////////////////
	// Stage 3, shift, ReLU, saturate

	always_ff @(posedge clk) begin
		if (v2) begin
			for (int l = 0; l < N_LANES; l++)
				res_q[RES_W*l +: RES_W] <= clamp(acc_q[l] >>> shift, relu);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			v3 <= 1'b0;
		end else begin
			v1 <= win_valid;
			v2 <= v1;
			v3 <= v2;
		end
	end

	assign res_data = res_q;
	assign res_valid = v3;
	assign pipe_busy = v1 || v2 || v3; // Windows still in flight

endmodule

// File: pe/feature_fetch.sv
`timescale 1ns/1ps

module feature_fetch import cnn_cfg_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,

	input  logic                  start,
	input  logic [MEM_ADDR_W-1:0] mem_addr_in,
	input  logic [LEN_W-1:0]      count,
	input  logic [ROW_ADDR_W-1:0] row,
	input  logic                  use_bias,
	input  logic [3:0]            shift,
	input  logic                  relu,

	output logic [MEM_ADDR_W-1:0] addr,
	output logic [LEN_W-1:0]      len,
	output logic                  conf,
	input  logic                  empty,
	output logic                  req,
	input  window_t               mem_data,

	input  logic                  pipe_busy,
	output logic [ROW_ADDR_W-1:0] w_row_addr,
	output logic [ROW_ADDR_W-1:0] b_row_addr,
	output window_t               win,
	output logic                  win_valid,
	output logic                  cfg_use_bias,
	output logic [3:0]            cfg_shift,
	output logic                  cfg_relu,

	output logic                  busy
);

	logic [LEN_W-1:0] req_cnt;
	logic [LEN_W-1:0] rx_cnt;

	assign conf = start;
	assign addr = mem_addr_in;
	assign len = count;

	assign req = busy && (req_cnt != count) && !empty; // One window per cycle
	assign win = mem_data;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			win_valid <= 1'b0;
			req_cnt <= '0;
			rx_cnt <= '0;
		end else begin
			win_valid <= req;
			if (start) begin
				busy <= 1'b1;
				req_cnt <= '0;
				rx_cnt <= '0;
			end else begin
				if (req)
					req_cnt <= req_cnt + 1'b1;
				if (win_valid)
					rx_cnt <= rx_cnt + 1'b1;
				// Hold until the PE pipeline has drained
				if (busy && (rx_cnt == count) && !win_valid && !pipe_busy)
					busy <= 1'b0;
			end
		end
	end

	// Coefficient rows and post-processing fixed for the whole run
	always_ff @(posedge clk) begin
		if (start) begin
			w_row_addr <= row;
			b_row_addr <= row;
			cfg_use_bias <= use_bias;
			cfg_shift <= shift;
			cfg_relu <= relu;
		end
	end

endmodule

// File: logic/coef_loader.sv
`timescale 1ns/1ps

module coef_loader import cnn_cfg_pkg::*; #(
	parameter int  ROWS = 64,
	parameter int  LANES_PER_ROW = N_LANES,
	parameter type row_t = weight_row_t
) (
	input  logic                  clk,
	input  logic                  reset,

	input  logic                  start,
	input  logic [MEM_ADDR_W-1:0] mem_addr_in,
	input  logic [LEN_W-1:0]      count,
	input  logic [ROW_ADDR_W-1:0] row,

	output logic [MEM_ADDR_W-1:0] addr,
	output logic [LEN_W-1:0]      len,
	output logic                  conf,
	input  logic                  empty,
	output logic                  req,
	input  window_t               mem_data,

	input  logic [ROW_ADDR_W-1:0] rd_row,
	output row_t                  rd_data,

	output logic                  busy
);

	localparam int LANE_W = $bits(row_t) / LANES_PER_ROW;
	localparam int LANE_IDX_W = (LANES_PER_ROW > 1) ? $clog2(LANES_PER_ROW) : 1;

	row_t                  rows_q [ROWS];
	logic [LEN_W-1:0]      req_cnt;
	logic                  wr_pend;  // Word arrives this cycle
	logic [ROW_ADDR_W-1:0] wr_row;
	logic [LANE_IDX_W-1:0] wr_lane;

	// Configure on the start cycle, fields are held by the decoder
	assign conf = start;
	assign addr = mem_addr_in;
	assign len = count;

	assign req = busy && (req_cnt != count) && !empty;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			wr_pend <= 1'b0;
			req_cnt <= '0;
			wr_row <= '0;
			wr_lane <= '0;
		end else begin
			wr_pend <= req;
			if (start) begin
				busy <= 1'b1;
				req_cnt <= '0;
				wr_row <= row;
				wr_lane <= '0;
			end else begin
				if (req)
					req_cnt <= req_cnt + 1'b1;
				if (wr_pend) begin
					if (wr_lane == LANE_IDX_W'(LANES_PER_ROW - 1)) begin
						wr_lane <= '0;
						wr_row <= wr_row + 1'b1; // Row full, move on
					end else begin
						wr_lane <= wr_lane + 1'b1;
					end
				end
				// Done once the last requested word is written
				if (busy && (req_cnt == count) && !wr_pend)
					busy <= 1'b0;
			end
		end
	end

	// Low bits of each word fill one lane slice
	always_ff @(posedge clk) begin
		if (wr_pend)
			rows_q[wr_row][wr_lane*LANE_W +: LANE_W] <= mem_data[LANE_W-1:0];
	end

	assign rd_data = rows_q[rd_row];

endmodule

// File: logic/mem_port_mux.sv
`timescale 1ns/1ps

module mem_port_mux import cnn_cfg_pkg::*, cnn_inst_pkg::*; (
	input  mem_sel_t              sel,

	input  logic [MEM_ADDR_W-1:0] w_addr,
	input  logic [LEN_W-1:0]      w_len,
	input  logic                  w_conf,
	input  logic                  w_req,

	input  logic [MEM_ADDR_W-1:0] b_addr,
	input  logic [LEN_W-1:0]      b_len,
	input  logic                  b_conf,
	input  logic                  b_req,

	input  logic [MEM_ADDR_W-1:0] f_addr,
	input  logic [LEN_W-1:0]      f_len,
	input  logic                  f_conf,
	input  logic                  f_req,

	input  logic                  mem_empty,
	output logic [MEM_ADDR_W-1:0] mem_addr,
	output logic [LEN_W-1:0]      mem_len,
	output logic                  mem_conf,
	output logic                  mem_req,

	output logic                  w_empty,
	output logic                  b_empty,
	output logic                  f_empty
);

	////////////////////
	// Command side, unit to memory

	always_comb begin
		mem_addr = '0;
		mem_len = '0;
		mem_conf = 1'b0;
		mem_req = 1'b0;
		case (sel)
			SEL_W: begin
				mem_addr = w_addr;
				mem_len = w_len;
				mem_conf = w_conf;
				mem_req = w_req;
			end
			SEL_B: begin
				mem_addr = b_addr;
				mem_len = b_len;
				mem_conf = b_conf;
				mem_req = b_req;
			end
			SEL_F: begin
				mem_addr = f_addr;
				mem_len = f_len;
				mem_conf = f_conf;
				mem_req = f_req;
			end
			default: ;
		endcase
	end

	////////////////////
	// Status side, memory to unit

	// Unselected units see an empty stream
	always_comb begin
		w_empty = (sel == SEL_W) ? mem_empty : 1'b1;
		b_empty = (sel == SEL_B) ? mem_empty : 1'b1;
		f_empty = (sel == SEL_F) ? mem_empty : 1'b1;
	end

endmodule

// File: logic/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import cnn_inst_pkg::*; (
	input  logic     clk,
	input  logic     reset,

	input  logic     inst_empty,
	input  inst_t    instruct,
	output logic     inst_req,

	input  logic     w_busy,
	input  logic     b_busy,
	input  logic     f_busy,

	output logic     w_start,
	output logic     b_start,
	output logic     f_start,
	output inst_t    cur,
	output mem_sel_t sel,
	output logic     idle
);

	typedef enum logic [1:0] {
		S_FETCH,
		S_DECODE,
		S_START,
		S_WAIT
	} state_t;

	state_t state;
	logic   unit_busy;

	// One pulse per instruction, only out of FETCH
	assign inst_req = (state == S_FETCH) && !inst_empty;
	assign idle = (state == S_FETCH);

	assign w_start = (state == S_START) && (cur.opcode == LOAD_W);
	assign b_start = (state == S_START) && (cur.opcode == LOAD_B);
	assign f_start = (state == S_START) && (cur.opcode == COMPUTE);

	// Busy of whichever unit the current opcode started
	always_comb begin
		case (cur.opcode)
			LOAD_W:  unit_busy = w_busy;
			LOAD_B:  unit_busy = b_busy;
			COMPUTE: unit_busy = f_busy;
			default: unit_busy = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_FETCH;
			sel <= SEL_W;
		end else begin
			case (state)
				S_FETCH: begin
					if (inst_req)
						state <= S_DECODE; // Word shows up next cycle
				end
				S_DECODE: begin
					state <= S_START;
					case (instruct.opcode)
						LOAD_W:  sel <= SEL_W;
						LOAD_B:  sel <= SEL_B;
						COMPUTE: sel <= SEL_F;
						default: sel <= sel; // NOP leaves the port alone
					endcase
				end
				S_START: begin
					state <= (cur.opcode == NOP) ? S_FETCH : S_WAIT;
				end
				S_WAIT: begin
					if (!unit_busy)
						state <= S_FETCH;
				end
				default: state <= S_FETCH;
			endcase
		end
	end

	// Instruction fields stay put until the unit is done
	always_ff @(posedge clk) begin
		if (state == S_DECODE)
			cur <= instruct;
	end

endmodule

// File: common/cnn_inst_pkg.sv
package cnn_inst_pkg;

	import cnn_cfg_pkg::*;

	typedef enum logic [1:0] {
		LOAD_W  = 2'd0, // Fill weight rows
		LOAD_B  = 2'd1, // Fill bias rows
		COMPUTE = 2'd2, // Stream windows through the PE array
		NOP     = 2'd3
	} opcode_t;

	// Used bits ahead of the padding
	localparam int INST_USED_W = 2 + MEM_ADDR_W + LEN_W + ROW_ADDR_W + 4 + 1 + 1;

	typedef struct packed {
		opcode_t                 opcode;
		logic [MEM_ADDR_W-1:0]   mem_addr; // First memory word
		logic [LEN_W-1:0]        count;    // Words or windows
		logic [ROW_ADDR_W-1:0]   row;      // First buffer row
		logic [3:0]              shift;    // Arithmetic right shift
		logic                    relu;
		logic                    use_bias;
		logic [64-INST_USED_W-1:0] pad;
	} inst_t;

	// Owner of the shared memory read port
	typedef enum logic [1:0] {
		SEL_W = 2'd0,
		SEL_B = 2'd1,
		SEL_F = 2'd2
	} mem_sel_t;

endpackage

// File: common/cnn_cfg_pkg.sv
package cnn_cfg_pkg;

	////////////////////
	// Array and memory sizes

	localparam int N_LANES = 4;     // Output lanes, one kernel each
	localparam int N_TAPS = 9;      // 3x3 kernel

	localparam int MEM_ADDR_W = 24; // Word address on the memory port
	localparam int LEN_W = 10;      // Word counts
	localparam int ROW_ADDR_W = 6;  // Coefficient buffer rows

	////////////////////
	// Datapath types

	typedef logic signed [7:0] pixel_t;

	// Tap k sits in byte k, also the memory word
	typedef logic [N_TAPS*$bits(pixel_t)-1:0] window_t;

	// Lane l kernel at bits 72l up
	typedef logic [N_LANES*$bits(window_t)-1:0] weight_row_t;

	typedef logic signed [15:0] bias_t;
	typedef logic [N_LANES*$bits(bias_t)-1:0] bias_row_t;

	// Holds 9 full products plus a bias with headroom
	typedef logic signed [23:0] acc_t;

	typedef logic signed [15:0] result_t;
	typedef logic [N_LANES*$bits(result_t)-1:0] result_row_t;

endpackage
